// File: axi_sram_wr.f
+incdir+src
src/axi_sram_wr_pkg.sv
src/axi_wr_burst_decode.sv
src/axi_wr_beat_exec.sv
src/axi_wr_resp.sv
src/axi_sram_wr_top.sv
tb/axi_sram_wr_tb.sv

// File: Bender.yml
package:
  name: axi_sram_wr

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      # Package first, then the blocks, then the top level
      - src/axi_sram_wr_pkg.sv
      - src/axi_wr_burst_decode.sv
      - src/axi_wr_beat_exec.sv
      - src/axi_wr_resp.sv
      - src/axi_sram_wr_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - tb/axi_sram_wr_tb.sv

// File: tb/axi_sram_wr_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_wr_defines.svh"

module axi_sram_wr_tb
  import axi_sram_wr_pkg::*;
();

  // One burst per row; a negative w_delay presents W before AW
  typedef struct packed {
    logic [`AXI_ADDR_WIDTH-1:0] addr;
    logic [`AXI_LEN_WIDTH-1:0]  len;
    logic [`AXI_SIZE_WIDTH-1:0] size;
    logic [1:0]                 burst;
    logic [`AXI_ID_WIDTH-1:0]   id;
    logic [`AXI_DATA_WIDTH-1:0] data_base;
    int                         w_delay;
    logic                       stall;
    int                         b_delay;
  } row_t;

  logic                        clk;
  logic                        rst_n;
  logic                        s_axi_awvalid;
  logic                        s_axi_awready;
  logic [`AXI_ID_WIDTH-1:0]    s_axi_awid;
  logic [`AXI_ADDR_WIDTH-1:0]  s_axi_awaddr;
  logic [`AXI_LEN_WIDTH-1:0]   s_axi_awlen;
  logic [`AXI_SIZE_WIDTH-1:0]  s_axi_awsize;
  logic [1:0]                  s_axi_awburst;
  logic                        s_axi_wvalid;
  logic                        s_axi_wready;
  logic [`AXI_DATA_WIDTH-1:0]  s_axi_wdata;
  logic [`AXI_STRB_WIDTH-1:0]  s_axi_wstrb;
  logic                        s_axi_bvalid;
  logic                        s_axi_bready;
  logic [`AXI_ID_WIDTH-1:0]    s_axi_bid;
  resp_e                       s_axi_bresp;
  logic                        sram_wr_cmd_valid;
  logic                        sram_wr_cmd_ready;
  logic [`SRAM_ADDR_WIDTH-1:0] sram_wr_cmd_addr;
  logic [`AXI_DATA_WIDTH-1:0]  sram_wr_cmd_data;
  logic [`AXI_STRB_WIDTH-1:0]  sram_wr_cmd_strb;

  row_t                        rows[$];
  logic [`SRAM_ADDR_WIDTH-1:0] exp_addr[$];
  logic [`AXI_DATA_WIDTH-1:0]  exp_data[$];
  logic [`AXI_STRB_WIDTH-1:0]  exp_strb[$];
  logic [`SRAM_ADDR_WIDTH-1:0] want_addr;
  logic [`AXI_DATA_WIDTH-1:0]  want_data;
  logic [`AXI_STRB_WIDTH-1:0]  want_strb;
  logic [31:0]                 data_state = 32'h98ff_3b72;
  logic [31:0]                 stall_state = 32'h98ff_3b72;
  logic                        stall_en = 1'b0;
  int                          watchdog_cycles = 0;

  axi_sram_wr_top dut_i (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t ns: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_run(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic add_row(input logic [19:0] addr, input logic [7:0] len, input logic [2:0] size,
                         input logic [1:0] burst, input logic [3:0] id, input logic [15:0] base,
                         input int w_delay, input logic stall, input int b_delay);
    row_t r;
    r = '{addr, len, size, burst, id, base, w_delay, stall, b_delay};
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_row(20'h00100, 8'd0,   3'd1, INCR,  4'h3, 16'h1000, 0,  1'b0, 0);
    add_row(20'h00200, 8'd3,   3'd1, INCR,  4'h5, 16'h2000, 1,  1'b0, 0);
    add_row(20'h00301, 8'd7,   3'd0, INCR,  4'h6, 16'h3000, 0,  1'b0, 1);
    add_row(20'h00380, 8'd15,  3'd1, INCR,  4'h7, 16'h3800, 2,  1'b1, 0);
    add_row(20'h00400, 8'd4,   3'd1, FIXED, 4'h8, 16'h4000, 0,  1'b0, 0);
    add_row(20'h00411, 8'd2,   3'd0, FIXED, 4'h2, 16'h4100, 0,  1'b1, 0);
    add_row(20'h00500, 8'd5,   3'd1, INCR,  4'hA, 16'h5000, -3, 1'b1, 0);
    add_row(20'h01000, 8'd255, 3'd1, INCR,  4'hB, 16'h6000, 0,  1'b1, 2);
    add_row(20'h00600, 8'd3,   3'd1, WRAP,  4'h9, 16'h7000, 0,  1'b1, 0);
    add_row(20'h00700, 8'd2,   3'd2, INCR,  4'hC, 16'h7100, 1,  1'b0, 0);
    add_row(20'h00800, 8'd0,   3'd1, RSVD,  4'hD, 16'h7200, 0,  1'b0, 0);
    add_row(20'h00900, 8'd1,   3'd1, INCR,  4'hE, 16'h8000, 0,  1'b0, 6);
    add_row(20'h00A02, 8'd2,   3'd1, FIXED, 4'hF, 16'h9000, 0,  1'b1, 4);
    add_row(20'h00B00, 8'd1,   3'd0, INCR,  4'h1, 16'hA000, -1, 1'b0, 0);
  endtask

  // Refused when the type is WRAP or reserved, or the beat is wider than the bus
  function automatic logic expect_err(input row_t r);
    return (r.burst == WRAP) || (r.burst == RSVD) || (r.size > `AXI_LSB);
  endfunction

  task automatic drive_aw(input row_t r);
    if (r.w_delay < 0) begin
      repeat (-r.w_delay) @(posedge clk);
      #1;
    end
    s_axi_awvalid = 1'b1;
    s_axi_awaddr  = r.addr;
    s_axi_awlen   = r.len;
    s_axi_awsize  = r.size;
    s_axi_awburst = r.burst;
    s_axi_awid    = r.id;
    do @(negedge clk); while (!s_axi_awready);
    @(posedge clk);
    #1;
    s_axi_awvalid = 1'b0;
  endtask

  task automatic drive_w(input row_t r);
    logic [`AXI_ADDR_WIDTH-1:0] byte_addr;
    logic [`AXI_STRB_WIDTH-1:0] strb;
    logic [`AXI_DATA_WIDTH-1:0] data;
    if (r.w_delay > 0) begin
      repeat (r.w_delay) @(posedge clk);
      #1;
    end
    for (int beat = 0; beat <= r.len; beat++) begin
      data_state = lcg(data_state);
      if (r.burst == INCR) begin
        byte_addr = r.addr + (`AXI_ADDR_WIDTH'(beat) << r.size);
      end else begin
        byte_addr = r.addr;
      end
      data = r.data_base + data_state[31:16];
      // Narrow beats use the lane of their own byte
      if (r.size == 0) begin
        strb = 2'b01 << byte_addr[0];
      end else begin
        strb = data_state[9:8];
      end
      if (!expect_err(r)) begin
        exp_addr.push_back(`SRAM_ADDR_WIDTH'(byte_addr >> `AXI_LSB));
        exp_data.push_back(data);
        exp_strb.push_back(strb);
      end
      s_axi_wvalid = 1'b1;
      s_axi_wdata  = data;
      s_axi_wstrb  = strb;
      do @(negedge clk); while (!s_axi_wready);
      @(posedge clk);
      #1;
    end
    s_axi_wvalid = 1'b0;
  endtask

  task automatic handle_b(input row_t r);
    resp_e want_resp;
    want_resp = expect_err(r) ? SLVERR : OKAY;
    do @(negedge clk); while (!s_axi_bvalid);
    assert (s_axi_bid == r.id)
      else report_mismatch($sformatf("bid %h, expected %h", s_axi_bid, r.id));
    assert (s_axi_bresp == want_resp)
      else report_mismatch($sformatf("bresp %0d, expected %0d", s_axi_bresp, want_resp));
    assert (exp_addr.size() == 0)
      else abort_run("B response came before every W beat reached the SRAM");
    // Response must hold while bready is low, and AW stays blocked
    repeat (r.b_delay) begin
      @(negedge clk);
      assert (s_axi_bvalid && s_axi_bid == r.id && s_axi_bresp == want_resp)
        else report_mismatch("B response changed while bready was low");
      assert (!s_axi_awready)
        else report_mismatch("awready high while a B response is pending");
    end
    @(posedge clk);
    #1;
    s_axi_bready = 1'b1;
    @(posedge clk);
    #1;
    s_axi_bready = 1'b0;
    @(negedge clk);
    assert (!s_axi_bvalid && s_axi_awready)
      else report_mismatch("bvalid or awready wrong after the B transfer");
    @(posedge clk);
    #1;
  endtask

  // SRAM sink with optional random back-pressure
  always @(posedge clk) begin
    #1;
    stall_state = lcg(stall_state);
    if (stall_en) begin
      sram_wr_cmd_ready = (stall_state[21:20] != 2'b00);
    end else begin
      sram_wr_cmd_ready = 1'b1;
    end
  end

  // Every SRAM write must match the oldest beat sent
  always @(negedge clk) begin
    if (rst_n && sram_wr_cmd_valid && sram_wr_cmd_ready) begin
      assert (exp_addr.size() > 0)
        else abort_run("SRAM write command issued with no W beat pending");
      want_addr = exp_addr.pop_front();
      want_data = exp_data.pop_front();
      want_strb = exp_strb.pop_front();
      assert (sram_wr_cmd_addr == want_addr)
        else report_mismatch($sformatf("SRAM addr %h, expected %h", sram_wr_cmd_addr, want_addr));
      assert (sram_wr_cmd_data == want_data)
        else report_mismatch($sformatf("SRAM data %h, expected %h", sram_wr_cmd_data, want_data));
      assert (sram_wr_cmd_strb == want_strb)
        else report_mismatch($sformatf("SRAM strb %b, expected %b", sram_wr_cmd_strb, want_strb));
    end
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    abort_run("timeout, the tests did not finish in the expected number of cycles");
  end

  initial begin
    int total_beats;
    clk               = 1'b0;
    rst_n             = 1'b0;
    s_axi_awvalid     = 1'b0;
    s_axi_awid        = '0;
    s_axi_awaddr      = '0;
    s_axi_awlen       = '0;
    s_axi_awsize      = '0;
    s_axi_awburst     = '0;
    s_axi_wvalid      = 1'b0;
    s_axi_wdata       = '0;
    s_axi_wstrb       = '0;
    s_axi_bready      = 1'b0;
    sram_wr_cmd_ready = 1'b0;
    build_table();
    total_beats = 0;
    foreach (rows[i]) total_beats += rows[i].len + 1;
    watchdog_cycles = total_beats * 20 + 200;

    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    assert (!s_axi_bvalid && !sram_wr_cmd_valid && !s_axi_wready)
      else report_mismatch("bvalid, wready or SRAM valid high after reset");
    assert (s_axi_awready)
      else report_mismatch("awready low after reset");
    @(posedge clk);
    #1;

    foreach (rows[i]) begin
      stall_en = rows[i].stall;
      fork
        drive_aw(rows[i]);
        drive_w(rows[i]);
        handle_b(rows[i]);
      join
    end

    repeat (2) @(posedge clk);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/axi_sram_wr_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_wr_defines.svh"

module axi_sram_wr_top
  import axi_sram_wr_pkg::*;
(
  input  wire logic                        clk,
  input  wire logic                        rst_n,

  // AW channel
  input  wire logic                        s_axi_awvalid,
  output logic                             s_axi_awready,
  input  wire logic [`AXI_ID_WIDTH-1:0]    s_axi_awid,
  input  wire logic [`AXI_ADDR_WIDTH-1:0]  s_axi_awaddr,
  input  wire logic [`AXI_LEN_WIDTH-1:0]   s_axi_awlen,
  input  wire logic [`AXI_SIZE_WIDTH-1:0]  s_axi_awsize,
  input  wire logic [1:0]                  s_axi_awburst,

  // W channel
  input  wire logic                        s_axi_wvalid,
  output logic                             s_axi_wready,
  input  wire logic [`AXI_DATA_WIDTH-1:0]  s_axi_wdata,
  input  wire logic [`AXI_STRB_WIDTH-1:0]  s_axi_wstrb,

  // B channel
  output logic                             s_axi_bvalid,
  input  wire logic                        s_axi_bready,
  output logic [`AXI_ID_WIDTH-1:0]         s_axi_bid,
  output resp_e                            s_axi_bresp,

  // SRAM write command
  output logic                             sram_wr_cmd_valid,
  input  wire logic                        sram_wr_cmd_ready,
  output logic [`SRAM_ADDR_WIDTH-1:0]      sram_wr_cmd_addr,
  output logic [`AXI_DATA_WIDTH-1:0]       sram_wr_cmd_data,
  output logic [`AXI_STRB_WIDTH-1:0]       sram_wr_cmd_strb
);

  logic                        burst_valid;
  logic [`AXI_ID_WIDTH-1:0]    burst_id;
  logic [`AXI_ADDR_WIDTH-1:0]  burst_addr;
  logic [`AXI_LEN_WIDTH-1:0]   burst_len;
  logic [`AXI_SIZE_WIDTH-1:0]  burst_size;
  logic                        burst_fixed;
  logic                        burst_err;
  logic                        burst_done;
  logic                        resp_busy;

  axi_wr_burst_decode decode_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_awid    (s_axi_awid),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awlen   (s_axi_awlen),
    .s_axi_awsize  (s_axi_awsize),
    .s_axi_awburst (s_axi_awburst),
    .burst_done    (burst_done),
    .resp_busy     (resp_busy),
    .burst_valid   (burst_valid),
    .burst_id      (burst_id),
    .burst_addr    (burst_addr),
    .burst_len     (burst_len),
    .burst_size    (burst_size),
    .burst_fixed   (burst_fixed),
    .burst_err     (burst_err)
  );

  axi_wr_beat_exec exec_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .burst_valid       (burst_valid),
    .burst_addr        (burst_addr),
    .burst_len         (burst_len),
    .burst_size        (burst_size),
    .burst_fixed       (burst_fixed),
    .burst_err         (burst_err),
    .s_axi_wvalid      (s_axi_wvalid),
    .s_axi_wready      (s_axi_wready),
    .s_axi_wdata       (s_axi_wdata),
    .s_axi_wstrb       (s_axi_wstrb),
    .burst_done        (burst_done),
    .sram_wr_cmd_valid (sram_wr_cmd_valid),
    .sram_wr_cmd_ready (sram_wr_cmd_ready),
    .sram_wr_cmd_addr  (sram_wr_cmd_addr),
    .sram_wr_cmd_data  (sram_wr_cmd_data),
    .sram_wr_cmd_strb  (sram_wr_cmd_strb)
  );

  axi_wr_resp resp_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .burst_done   (burst_done),
    .burst_err    (burst_err),
    .burst_id     (burst_id),
    .s_axi_bvalid (s_axi_bvalid),
    .s_axi_bready (s_axi_bready),
    .s_axi_bid    (s_axi_bid),
    .s_axi_bresp  (s_axi_bresp),
    .resp_busy    (resp_busy)
  );

endmodule

`default_nettype wire

// File: src/axi_wr_resp.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_wr_defines.svh"

module axi_wr_resp
  import axi_sram_wr_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      rst_n,

  input  wire logic                      burst_done,
  input  wire logic                      burst_err,
  input  wire logic [`AXI_ID_WIDTH-1:0]  burst_id,

  output logic                           s_axi_bvalid,
  input  wire logic                      s_axi_bready,
  output logic [`AXI_ID_WIDTH-1:0]       s_axi_bid,
  output resp_e                          s_axi_bresp,

  output logic                           resp_busy
);

  // Response pending
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s_axi_bvalid <= 1'b0;
    end else if (burst_done) begin
      s_axi_bvalid <= 1'b1;
    end else if (s_axi_bready) begin
      s_axi_bvalid <= 1'b0;
    end
  end

  // ID and status, held steady while bvalid waits
  always_ff @(posedge clk) begin
    if (burst_done) begin
      s_axi_bid <= burst_id;
      if (burst_err) begin
        s_axi_bresp <= SLVERR;
      end else begin
        s_axi_bresp <= OKAY;
      end
    end
  end

  // Blocks the next AW until B is taken
  assign resp_busy = s_axi_bvalid;

endmodule

`default_nettype wire

// File: src/axi_wr_beat_exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_wr_defines.svh"

module axi_wr_beat_exec (
  input  wire logic                        clk,
  input  wire logic                        rst_n,

  input  wire logic                        burst_valid,
  input  wire logic [`AXI_ADDR_WIDTH-1:0]  burst_addr,
  input  wire logic [`AXI_LEN_WIDTH-1:0]   burst_len,
  input  wire logic [`AXI_SIZE_WIDTH-1:0]  burst_size,
  input  wire logic                        burst_fixed,
  input  wire logic                        burst_err,

  input  wire logic                        s_axi_wvalid,
  output logic                             s_axi_wready,
  input  wire logic [`AXI_DATA_WIDTH-1:0]  s_axi_wdata,
  input  wire logic [`AXI_STRB_WIDTH-1:0]  s_axi_wstrb,

  output logic                             burst_done,

  output logic                             sram_wr_cmd_valid,
  input  wire logic                        sram_wr_cmd_ready,
  output logic [`SRAM_ADDR_WIDTH-1:0]      sram_wr_cmd_addr,
  output logic [`AXI_DATA_WIDTH-1:0]       sram_wr_cmd_data,
  output logic [`AXI_STRB_WIDTH-1:0]       sram_wr_cmd_strb
);

  logic [`AXI_LEN_WIDTH-1:0]  beat_q;
  logic [`AXI_ADDR_WIDTH-1:0] addr_q;
  logic [`AXI_ADDR_WIDTH-1:0] cur_addr;
  logic [`AXI_ADDR_WIDTH-1:0] next_addr;
  logic                       first_beat;
  logic                       last_beat;
  logic                       beat_xfer;

  assign first_beat = (beat_q == '0);
  assign last_beat  = (beat_q == burst_len);

  // First beat takes the AW address directly, so it can go
  // out in the same cycle burst_valid rises
  assign cur_addr = first_beat ? burst_addr : addr_q;

  always_comb begin
    if (burst_fixed) begin
      next_addr = cur_addr;
    end else begin
      next_addr = cur_addr + (`AXI_ADDR_WIDTH'(1) << burst_size);
    end
  end

  // Error bursts swallow beats without waiting on the SRAM
  assign s_axi_wready      = burst_valid && (burst_err || sram_wr_cmd_ready);
  assign sram_wr_cmd_valid = burst_valid && !burst_err && s_axi_wvalid;

  assign beat_xfer  = s_axi_wvalid && s_axi_wready;
  assign burst_done = beat_xfer && last_beat;

  // Word address for the SRAM
  assign sram_wr_cmd_addr = cur_addr[`AXI_ADDR_WIDTH-1:`AXI_LSB];

  // Narrow strobes pass through untouched
  assign sram_wr_cmd_data = s_axi_wdata;
  assign sram_wr_cmd_strb = s_axi_wstrb;

  // Beat counter, back to zero after the last beat
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_q <= '0;
    end else if (beat_xfer) begin
      if (last_beat) begin
        beat_q <= '0;
      end else begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // Running byte address
  always_ff @(posedge clk) begin
    if (beat_xfer) begin
      addr_q <= next_addr;
    end
  end

endmodule

`default_nettype wire

// File: src/axi_wr_burst_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_wr_defines.svh"

module axi_wr_burst_decode
  import axi_sram_wr_pkg::*;
(
  input  wire logic                        clk,
  input  wire logic                        rst_n,

  input  wire logic                        s_axi_awvalid,
  output logic                             s_axi_awready,
  input  wire logic [`AXI_ID_WIDTH-1:0]    s_axi_awid,
  input  wire logic [`AXI_ADDR_WIDTH-1:0]  s_axi_awaddr,
  input  wire logic [`AXI_LEN_WIDTH-1:0]   s_axi_awlen,
  input  wire logic [`AXI_SIZE_WIDTH-1:0]  s_axi_awsize,
  input  wire logic [1:0]                  s_axi_awburst,

  input  wire logic                        burst_done,
  input  wire logic                        resp_busy,

  output logic                             burst_valid,
  output logic [`AXI_ID_WIDTH-1:0]         burst_id,
  output logic [`AXI_ADDR_WIDTH-1:0]       burst_addr,
  output logic [`AXI_LEN_WIDTH-1:0]        burst_len,
  output logic [`AXI_SIZE_WIDTH-1:0]       burst_size,
  output logic                             burst_fixed,
  output logic                             burst_err
);

  logic   aw_xfer;
  burst_e aw_type;
  logic   aw_bad_type;
  logic   aw_bad_size;

  // Idle and no response pending
  assign s_axi_awready = !burst_valid && !resp_busy;
  assign aw_xfer       = s_axi_awvalid && s_axi_awready;

  assign aw_type = burst_e'(s_axi_awburst);

  always_comb begin
    aw_bad_type = 1'b0;
    case (aw_type)
      WRAP:    aw_bad_type = 1'b1;
      RSVD:    aw_bad_type = 1'b1;
      default: aw_bad_type = 1'b0;
    endcase
  end

  // Beats wider than the bus
  assign aw_bad_size = s_axi_awsize > `AXI_SIZE_WIDTH'(`AXI_LSB);

  // Burst in flight
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      burst_valid <= 1'b0;
    end else if (aw_xfer) begin
      burst_valid <= 1'b1;
    end else if (burst_done) begin
      burst_valid <= 1'b0;
    end
  end

  // Burst fields, held until the last beat
  always_ff @(posedge clk) begin
    if (aw_xfer) begin
      burst_id    <= s_axi_awid;
      burst_addr  <= s_axi_awaddr;
      burst_len   <= s_axi_awlen;
      burst_size  <= s_axi_awsize;
      burst_fixed <= (aw_type == FIXED);
      burst_err   <= aw_bad_type || aw_bad_size;
    end
  end

endmodule

`default_nettype wire

// File: src/axi_sram_wr_pkg.sv
`default_nettype none

package axi_sram_wr_pkg;

  // Same encoding as awburst
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10,
    RSVD  = 2'b11
  } burst_e;

  // Same encoding as bresp
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

endpackage

`default_nettype wire

// File: src/axi_sram_wr_defines.svh
`ifndef AXI_SRAM_WR_DEFINES_SVH
`define AXI_SRAM_WR_DEFINES_SVH

// AXI slave port geometry
`define AXI_ADDR_WIDTH 20
`define AXI_DATA_WIDTH 16
`define AXI_ID_WIDTH 4

// Bytes per beat
`define AXI_STRB_WIDTH (`AXI_DATA_WIDTH / 8)

// Byte offset bits within one bus word
`define AXI_LSB ($clog2(`AXI_STRB_WIDTH))

// SRAM side is word addressed
`define SRAM_ADDR_WIDTH (`AXI_ADDR_WIDTH - `AXI_LSB)

// AW length and size fields
`define AXI_LEN_WIDTH 8
`define AXI_SIZE_WIDTH 3

`endif
